/* sim/gat_aggr_checker.sv */
`timescale 1ns/1ps

module gat_aggr_checker #(
  parameter int WH_FIFO_DEPTH   = 4,
  parameter int COEF_FIFO_DEPTH = 4,
  parameter int FEAT_ADDR_W     = 6
) (
  input logic                   clk,
  input logic                   rst_n,
  input gat_pkg::wh_row_t       wh_in,
  input logic                   wh_valid,
  input logic                   wh_ready,
  input logic                   wh_pop,
  input gat_pkg::coef_beat_t    coef_in,
  input logic                   coef_valid,
  input logic                   coef_ready,
  input logic                   coef_pop,
  input logic                   feat_bram_en,
  input logic [FEAT_ADDR_W-1:0] feat_bram_addr
);

  import gat_pkg::*;

  int                     fail_count = 0;
  logic                   node_sent;
  logic                   wrote;
  logic [FEAT_ADDR_W-1:0] last_addr;
  int                     wh_fill;
  int                     coef_fill;

  // Tracks the first completed node and the previous write address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_sent <= 1'b0;
      wrote     <= 1'b0;
      last_addr <= '0;
    end else begin
      if (coef_valid && coef_ready && coef_in.last) begin
        node_sent <= 1'b1;
      end
      if (feat_bram_en) begin
        wrote     <= 1'b1;
        last_addr <= feat_bram_addr;
      end
    end
  end

  // Input queue fill from accepted beats and aggregator pops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_fill   <= 0;
      coef_fill <= 0;
    end else begin
      wh_fill   <= wh_fill + int'(wh_valid && wh_ready) - int'(wh_pop);
      coef_fill <= coef_fill + int'(coef_valid && coef_ready) - int'(coef_pop);
    end
  end

  // ==========================================================
  // Reset, idle and input handshake rules
  // ==========================================================

  idle_until_node: assert property (@(posedge clk) !node_sent |-> !feat_bram_en)
    else begin
      fail_count++;
      $error("BRAM write before any complete node was sent");
    end

  wh_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid && !wh_ready |=> wh_valid && $stable(wh_in))
    else begin
      fail_count++;
      $error("WH beat changed or dropped while stalled");
    end

  coef_hold: assert property (@(posedge clk) disable iff (!rst_n)
    coef_valid && !coef_ready |=> coef_valid && $stable(coef_in))
    else begin
      fail_count++;
      $error("Coefficient beat changed or dropped while stalled");
    end

  // Input queues refuse data only when full
  wh_ready_fill: assert property (@(posedge clk) disable iff (!rst_n)
    wh_ready == (wh_fill != WH_FIFO_DEPTH))
    else begin
      fail_count++;
      $error("WH ready does not match the WH queue fill");
    end

  coef_ready_fill: assert property (@(posedge clk) disable iff (!rst_n)
    coef_ready == (coef_fill != COEF_FIFO_DEPTH))
    else begin
      fail_count++;
      $error("Coefficient ready does not match the coefficient queue fill");
    end

  // ==========================================================
  // BRAM write port rules
  // ==========================================================

  first_addr_zero: assert property (@(posedge clk) disable iff (!rst_n)
    feat_bram_en && !wrote |-> feat_bram_addr == '0)
    else begin
      fail_count++;
      $error("First BRAM write not at address 0");
    end

  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    feat_bram_en && wrote |-> feat_bram_addr == FEAT_ADDR_W'(last_addr + 1'b1))
    else begin
      fail_count++;
      $error("BRAM write address did not advance by one");
    end

  // A vector always goes out as one unbroken burst of lanes
  lane_burst: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(feat_bram_en) |-> feat_bram_en [*NUM_FEATURE_OUT])
    else begin
      fail_count++;
      $error("BRAM write burst shorter than one vector");
    end

endmodule

bind gat_aggr_top gat_aggr_checker #(
  .WH_FIFO_DEPTH   (WH_FIFO_DEPTH),
  .COEF_FIFO_DEPTH (COEF_FIFO_DEPTH),
  .FEAT_ADDR_W     (FEAT_ADDR_W)
) u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .wh_in          (wh_in),
  .wh_valid       (wh_valid),
  .wh_ready       (wh_ready),
  .wh_pop         (wh_pop),
  .coef_in        (coef_in),
  .coef_valid     (coef_valid),
  .coef_ready     (coef_ready),
  .coef_pop       (coef_pop),
  .feat_bram_en   (feat_bram_en),
  .feat_bram_addr (feat_bram_addr)
);

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for four rising edges, released off the edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
  end

endmodule

/* sim/tb_gat_aggr.sv */
`timescale 1ns/1ps

module tb_gat_aggr;

  import gat_pkg::*;

  localparam int FEAT_ADDR_W = 6;

  logic                         clk;
  logic                         rst_n;
  wh_row_t                      wh_in;
  logic                         wh_valid;
  logic                         wh_ready;
  coef_beat_t                   coef_in;
  logic                         coef_valid;
  logic                         coef_ready;
  logic                         feat_bram_en;
  logic [FEAT_ADDR_W-1:0]       feat_bram_addr;
  logic [NEW_FEATURE_WIDTH-1:0] feat_bram_din;

  // Stimulus and expected words built before reset release
  wh_row_t                      wh_q[$];
  int                           wh_gap_q[$];
  coef_beat_t                   coef_q[$];
  int                           coef_gap_q[$];
  logic [NEW_FEATURE_WIDTH-1:0] exp_q[$];

  logic [31:0]                  lfsr = 32'ha3b3_d2ca;
  logic [FEAT_ADDR_W-1:0]       exp_addr = '0;
  logic [NEW_FEATURE_WIDTH-1:0] exp_din;
  logic                         rows_done = 1'b0;
  logic                         coefs_done = 1'b0;
  int                           total_nb = 0;
  int                           total_nodes = 0;
  int                           cycles = 0;
  int                           limit = 0;
  int                           errors = 0;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_aggr_top #(
    .WH_FIFO_DEPTH   (4),
    .COEF_FIFO_DEPTH (4),
    .FEAT_FIFO_DEPTH (2),
    .FEAT_ADDR_W     (FEAT_ADDR_W)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .wh_in          (wh_in),
    .wh_valid       (wh_valid),
    .wh_ready       (wh_ready),
    .coef_in        (coef_in),
    .coef_valid     (coef_valid),
    .coef_ready     (coef_ready),
    .feat_bram_en   (feat_bram_en),
    .feat_bram_addr (feat_bram_addr),
    .feat_bram_din  (feat_bram_din)
  );

  // ==========================================================
  // Random source and reference model
  // ==========================================================

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int draw_gap(input int gap_max);
    return (gap_max == 0) ? 0 : int'(rand_bits(5)) % (gap_max + 1);
  endfunction

  // Kind 0 draws alpha, kind 1 uses full-scale alpha and kind 2 adds most negative lanes
  task automatic add_node(input int n_nb, input int kind, input int wh_gap_max,
                          input int coef_gap_max);
    longint     acc [NUM_FEATURE_OUT];
    wh_row_t    row;
    coef_beat_t beat;
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      acc[i] = 0;
    end
    for (int n = 0; n < n_nb; n++) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        if (kind == 2) begin
          row.lanes[i] = {1'b1, {(WH_DATA_WIDTH-1){1'b0}}};
        end else begin
          row.lanes[i] = WH_DATA_WIDTH'(rand_bits(WH_DATA_WIDTH));
        end
      end
      beat.alpha = (kind == 0) ? ALPHA_DATA_WIDTH'(rand_bits(ALPHA_DATA_WIDTH)) : '1;
      beat.last  = (n == n_nb - 1);
      // Signed lane times unsigned alpha is exact in 64 bits
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc[i] += longint'(row.lanes[i]) * longint'(beat.alpha);
      end
      wh_q.push_back(row);
      coef_q.push_back(beat);
      wh_gap_q.push_back(draw_gap(wh_gap_max));
      coef_gap_q.push_back(draw_gap(coef_gap_max));
    end
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      exp_q.push_back(NEW_FEATURE_WIDTH'(acc[i]));
    end
    total_nb    += n_nb;
    total_nodes += 1;
  endtask

  task automatic build_tests();
    // Single neighbor at full-scale alpha
    add_node(1, 1, 0, 0);
    // Several neighbors with signed lanes and then the negative corner
    repeat (4) add_node(2 + int'(rand_bits(4)) % 15, 0, 2, 2);
    add_node(MAX_NEIGHBORS, 2, 0, 0);
    // Slow coefficients against back-to-back rows and then the reverse
    repeat (3) add_node(1 + int'(rand_bits(4)), 0, 0, 15);
    repeat (3) add_node(1 + int'(rand_bits(4)), 0, 15, 0);
    // Single-neighbor run that fills the feature queue
    repeat (12) add_node(1, 0, 0, 0);
    // Long random mix
    repeat (40) add_node(1 + int'(rand_bits(4)), int'(rand_bits(2)) % 3,
                         int'(rand_bits(3)), int'(rand_bits(3)));
  endtask

  // ==========================================================
  // Stream drivers
  // ==========================================================

  task automatic send_rows();
    wh_row_t row;
    int      gap;
    logic    taken;
    while (wh_q.size() != 0) begin
      row = wh_q.pop_front();
      gap = wh_gap_q.pop_front();
      repeat (gap) begin
        @(posedge clk);
        #0.5;
      end
      wh_in    = row;
      wh_valid = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
        // Transfer happens on the next edge if ready is high now
        taken = wh_ready;
        @(posedge clk);
        #0.5;
      end
      wh_valid = 1'b0;
    end
    rows_done = 1'b1;
  endtask

  task automatic send_coefs();
    coef_beat_t beat;
    int         gap;
    logic       taken;
    while (coef_q.size() != 0) begin
      beat = coef_q.pop_front();
      gap  = coef_gap_q.pop_front();
      repeat (gap) begin
        @(posedge clk);
        #0.5;
      end
      coef_in    = beat;
      coef_valid = 1'b1;
      taken      = 1'b0;
      while (!taken) begin
        taken = coef_ready;
        @(posedge clk);
        #0.5;
      end
      coef_valid = 1'b0;
    end
    coefs_done = 1'b1;
  endtask

  // ==========================================================
  // Write scoreboard and cycle counter
  // ==========================================================

  // Sample mid-cycle where the write port is stable
  always @(negedge clk) begin
    cycles++;
    if (rst_n && feat_bram_en) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected BRAM write at %0t ns with no word left to expect", $time);
      end else begin
        exp_din = exp_q.pop_front();
        din_check: assert (feat_bram_din == exp_din)
          else begin
            errors++;
            $display("Fail at %0t ns: feat_bram_din expected %h, got %h",
                     $time, exp_din, feat_bram_din);
          end
        addr_check: assert (feat_bram_addr == exp_addr)
          else begin
            errors++;
            $display("Fail at %0t ns: feat_bram_addr expected %0d, got %0d",
                     $time, exp_addr, feat_bram_addr);
          end
        exp_addr = exp_addr + 1'b1;
      end
    end
  end

  initial begin
    wh_in      = '0;
    wh_valid   = 1'b0;
    coef_in    = '0;
    coef_valid = 1'b0;
    build_tests();
    limit = 20 * total_nb + 8 * total_nodes + 200;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #0.5;
    fork
      send_rows();
      send_coefs();
    join_none
    while (!(rows_done && coefs_done && exp_q.size() == 0) && cycles < limit) begin
      @(posedge clk);
    end
    if (!(rows_done && coefs_done && exp_q.size() == 0)) begin
      errors++;
      $display("Run stopped on timeout before all vectors were written");
    end else begin
      // Room for any stray write after the last vector
      repeat (20) @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Vectors missing at end of run, %0d words never written", exp_q.size());
    end
    $display("Error counts: testbench %0d, checker %0d", errors, DUT.u_checker.fail_count);
    if (errors == 0 && DUT.u_checker.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src.f */
src/gat_pkg.sv
src/sync_fifo.sv
src/neighbor_aggregator.sv
src/feature_controller.sv
src/gat_aggr_top.sv
sim/tb_clock.sv
sim/gat_aggr_checker.sv
sim/tb_gat_aggr.sv

/* src/feature_controller.sv */
`timescale 1ns/1ps

module feature_controller #(
  parameter int FEAT_FIFO_DEPTH = 2,
  parameter int FEAT_ADDR_W     = 6
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  gat_pkg::new_feat_t                    new_feat,
  input  logic                                  new_feat_valid,
  output logic                                  new_feat_ready,

  output logic                                  feat_bram_en,
  output logic [FEAT_ADDR_W-1:0]                feat_bram_addr,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0] feat_bram_din
);

  import gat_pkg::*;

  localparam int LANE_W = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;

  new_feat_t         fifo_head;
  logic              fifo_head_valid;
  logic              fifo_pop;

  new_feat_t         held;
  new_feat_t         cur_vec;
  logic [LANE_W-1:0] lane_cnt;
  logic [FEAT_ADDR_W-1:0] addr_reg;

  sync_fifo #(
    .payload_t (new_feat_t),
    .DEPTH     (FEAT_FIFO_DEPTH)
  ) u_feat_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (new_feat),
    .in_valid  (new_feat_valid),
    .in_ready  (new_feat_ready),
    .out       (fifo_head),
    .out_valid (fifo_head_valid),
    .out_ready (fifo_pop)
  );

  // ==========================================================
  // Lane sequencing
  // ==========================================================

  // Counter at zero means idle
  assign fifo_pop = (lane_cnt == '0) && fifo_head_valid;

  // Lane 0 comes straight from the queue head, later lanes from the held copy
  assign cur_vec = (lane_cnt == '0) ? fifo_head : held;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
    end else if (feat_bram_en) begin
      lane_cnt <= (lane_cnt == LANE_W'(NUM_FEATURE_OUT - 1)) ? '0 : lane_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      held <= fifo_head;
    end
  end

  // ==========================================================
  // BRAM write port
  // ==========================================================

  assign feat_bram_en   = fifo_pop || (lane_cnt != '0);
  assign feat_bram_din  = cur_vec.lanes[lane_cnt];
  assign feat_bram_addr = addr_reg;

  // Running address, wraps with its width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_reg <= '0;
    end else if (feat_bram_en) begin
      addr_reg <= addr_reg + 1'b1;
    end
  end

endmodule

/* src/gat_aggr_top.sv */
`timescale 1ns/1ps

module gat_aggr_top #(
  parameter int WH_FIFO_DEPTH   = 4,
  parameter int COEF_FIFO_DEPTH = 4,
  parameter int FEAT_FIFO_DEPTH = 2,
  parameter int FEAT_ADDR_W     = 6
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  gat_pkg::wh_row_t                      wh_in,
  input  logic                                  wh_valid,
  output logic                                  wh_ready,

  input  gat_pkg::coef_beat_t                   coef_in,
  input  logic                                  coef_valid,
  output logic                                  coef_ready,

  output logic                                  feat_bram_en,
  output logic [FEAT_ADDR_W-1:0]                feat_bram_addr,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0] feat_bram_din
);

  import gat_pkg::*;

  wh_row_t    wh_head;
  logic       wh_head_valid;
  logic       wh_pop;

  coef_beat_t coef_head;
  logic       coef_head_valid;
  logic       coef_pop;

  new_feat_t  feat_out;
  logic       feat_valid;
  logic       feat_ready;

  // ==========================================================
  // Input queues, side by side
  // ==========================================================

  sync_fifo #(
    .payload_t (wh_row_t),
    .DEPTH     (WH_FIFO_DEPTH)
  ) u_wh_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (wh_in),
    .in_valid  (wh_valid),
    .in_ready  (wh_ready),
    .out       (wh_head),
    .out_valid (wh_head_valid),
    .out_ready (wh_pop)
  );

  sync_fifo #(
    .payload_t (coef_beat_t),
    .DEPTH     (COEF_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (coef_in),
    .in_valid  (coef_valid),
    .in_ready  (coef_ready),
    .out       (coef_head),
    .out_valid (coef_head_valid),
    .out_ready (coef_pop)
  );

  // ==========================================================
  // Aggregation and BRAM writer
  // ==========================================================

  neighbor_aggregator u_aggregator (
    .clk             (clk),
    .rst_n           (rst_n),
    .wh_head         (wh_head),
    .wh_head_valid   (wh_head_valid),
    .wh_pop          (wh_pop),
    .coef_head       (coef_head),
    .coef_head_valid (coef_head_valid),
    .coef_pop        (coef_pop),
    .feat_out        (feat_out),
    .feat_valid      (feat_valid),
    .feat_ready      (feat_ready)
  );

  feature_controller #(
    .FEAT_FIFO_DEPTH (FEAT_FIFO_DEPTH),
    .FEAT_ADDR_W     (FEAT_ADDR_W)
  ) u_feat_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .new_feat        (feat_out),
    .new_feat_valid  (feat_valid),
    .new_feat_ready  (feat_ready),
    .feat_bram_en    (feat_bram_en),
    .feat_bram_addr  (feat_bram_addr),
    .feat_bram_din   (feat_bram_din)
  );

endmodule

/* src/gat_pkg.sv */
package gat_pkg;

  // ==========================================================
  // Vector geometry and number formats
  // ==========================================================

  // Output feature lanes per vector
  localparam int NUM_FEATURE_OUT = 8;

  // Signed WH lane
  localparam int WH_DATA_WIDTH = 12;

  // Unsigned alpha, fraction bits only
  localparam int ALPHA_DATA_WIDTH = 16;

  // Largest neighbor count per node
  localparam int MAX_NEIGHBORS = 16;

  // Full precision product plus sign bit plus guard bits for the neighbor sum
  localparam int NEW_FEATURE_WIDTH =
    WH_DATA_WIDTH + ALPHA_DATA_WIDTH + 1 + $clog2(MAX_NEIGHBORS);

  // ==========================================================
  // Lane and stream payload types
  // ==========================================================

  // Named signed lane types keep each selected lane signed
  typedef logic signed [WH_DATA_WIDTH-1:0]     wh_lane_t;
  typedef logic signed [NEW_FEATURE_WIDTH-1:0] feat_lane_t;

  // One transformed neighbor row, lane 0 in the low bits
  typedef struct packed {
    wh_lane_t [NUM_FEATURE_OUT-1:0] lanes;
  } wh_row_t;

  // One attention coefficient, last marks the node's final neighbor
  typedef struct packed {
    logic [ALPHA_DATA_WIDTH-1:0] alpha;
    logic                        last;
  } coef_beat_t;

  // Accumulated new feature vector
  typedef struct packed {
    feat_lane_t [NUM_FEATURE_OUT-1:0] lanes;
  } new_feat_t;

endpackage

/* src/neighbor_aggregator.sv */
`timescale 1ns/1ps

module neighbor_aggregator (
  input  logic                  clk,
  input  logic                  rst_n,

  input  gat_pkg::wh_row_t      wh_head,
  input  logic                  wh_head_valid,
  output logic                  wh_pop,

  input  gat_pkg::coef_beat_t   coef_head,
  input  logic                  coef_head_valid,
  output logic                  coef_pop,

  output gat_pkg::new_feat_t    feat_out,
  output logic                  feat_valid,
  input  logic                  feat_ready
);

  import gat_pkg::*;

  // Alpha seen as a non-negative signed value
  logic signed [ALPHA_DATA_WIDTH:0] alpha_s;

  logic      pair_valid;
  logic      last_pair;
  logic      out_free;
  logic      accept;
  logic      first_pair;

  new_feat_t prod;
  new_feat_t sum;
  new_feat_t acc;

  // ==========================================================
  // Pair acceptance
  // ==========================================================

  assign pair_valid = wh_head_valid && coef_head_valid;
  assign last_pair  = coef_head.last;

  // Output slot is free when empty or drained on this edge
  assign out_free = !feat_valid || feat_ready;

  // Last pair waits for the output slot, others never stall
  assign accept = pair_valid && (!last_pair || out_free);

  assign wh_pop   = accept;
  assign coef_pop = accept;

  // ==========================================================
  // Lane multiply and accumulate
  // ==========================================================

  assign alpha_s = {1'b0, coef_head.alpha};

  // Operands are sign extended to the full lane width before the multiply
  always_comb begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      prod.lanes[i] = $signed(wh_head.lanes[i]) * alpha_s;
      if (first_pair) begin
        sum.lanes[i] = prod.lanes[i];
      end else begin
        sum.lanes[i] = acc.lanes[i] + prod.lanes[i];
      end
    end
  end

  // Set while no pair of the current node has been taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_pair <= 1'b1;
    end else if (accept) begin
      first_pair <= last_pair;
    end
  end

  // Running per-lane sums of the node in progress
  always_ff @(posedge clk) begin
    if (accept && !last_pair) begin
      acc <= sum;
    end
  end

  // ==========================================================
  // Finished vector register
  // ==========================================================

  always_ff @(posedge clk) begin
    if (accept && last_pair) begin
      feat_out <= sum;
    end
  end

  // Next node keeps accumulating while this one waits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_valid <= 1'b0;
    end else if (accept && last_pair) begin
      feat_valid <= 1'b1;
    end else if (feat_ready) begin
      feat_valid <= 1'b0;
    end
  end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Head is read straight from storage
  assign out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in;
    end
  end

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule
